// ==== common/exec_cluster_config.svh ====
`ifndef EXEC_CLUSTER_CONFIG_SVH
`define EXEC_CLUSTER_CONFIG_SVH

// number of execute lanes, also the in-flight limit.
`define EXEC_LANES 3

// datapath width of an RV32 core.
`define EXEC_XLEN 32

`endif

// ==== common/exec_pkg.sv ====
`include "exec_cluster_config.svh"

package exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // how the raw immediate field turns into an operand.
    typedef enum logic [1:0] {
        IMM_I12 = 2'd0, // sign-extended 12 bits.
        IMM_U20 = 2'd1, // upper 20 bits.
        IMM_J20 = 2'd2, // sign-extended 20 bits, halfword aligned.
        IMM_U5  = 2'd3  // zero-extended 5 bits.
    } imm_kind_e;

    typedef enum logic [1:0] {
        SRC1_RS1  = 2'd0,
        SRC1_PC   = 2'd1,
        SRC1_ZERO = 2'd2
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_IMM  = 2'd0,
        SRC2_RS2  = 2'd1,
        SRC2_CSR  = 2'd2,
        SRC2_ZERO = 2'd3
    } src2_sel_e;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] pc;
        logic [`EXEC_XLEN-1:0] rs1_value;
        logic [`EXEC_XLEN-1:0] rs2_value;
        logic [`EXEC_XLEN-1:0] csr_value;
        logic [`EXEC_XLEN-1:0] imm;
        imm_kind_e             imm_kind;
        alu_op_e               alu_op;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic                  invert;   // flips bit 0, slt used as sge.
        logic [4:0]            rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
    } uop_t;

    typedef struct packed {
        logic [`EXEC_XLEN-1:0] value;
        logic [`EXEC_XLEN-1:0] store_data;
        logic [`EXEC_XLEN-1:0] pc;
        logic [4:0]            rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
    } result_t;

endpackage

// ==== exu/exu_lane.sv ====
`timescale 1ns/1ps
`include "exec_cluster_config.svh"

module exu_lane (
    input  logic              clock,
    input  logic              reset,
    input  logic              load,
    input  exec_pkg::uop_t    uop,
    input  logic              pop,
    output logic              busy,
    output exec_pkg::result_t result
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] imm_value;
    logic [`EXEC_XLEN-1:0] src1;
    logic [`EXEC_XLEN-1:0] src2;
    logic [`EXEC_XLEN-1:0] alu_out;
    logic [4:0]            shamt;
    result_t               result_next;

    // immediate forming.
    always_comb begin
        unique case (uop.imm_kind)
            IMM_I12: imm_value = {{(`EXEC_XLEN-12){uop.imm[11]}}, uop.imm[11:0]};
            IMM_U20: imm_value = uop.imm << 12;
            IMM_J20: imm_value = {{(`EXEC_XLEN-21){uop.imm[19]}}, uop.imm[19:0], 1'b0};
            IMM_U5:  imm_value = {{(`EXEC_XLEN-5){1'b0}}, uop.imm[4:0]};
            default: imm_value = '0;
        endcase
    end

    always_comb begin
        unique case (uop.src1_sel)
            SRC1_RS1: src1 = uop.rs1_value;
            SRC1_PC:  src1 = uop.pc;
            default:  src1 = '0; // zero select and the unused code.
        endcase
    end

    always_comb begin
        unique case (uop.src2_sel)
            SRC2_IMM: src2 = imm_value;
            SRC2_RS2: src2 = uop.rs2_value;
            SRC2_CSR: src2 = uop.csr_value;
            default:  src2 = '0;
        endcase
    end

    assign shamt = src2[4:0];

    always_comb begin
        unique case (uop.alu_op)
            ALU_ADD:  alu_out = src1 + src2;
            ALU_SUB:  alu_out = src1 - src2;
            ALU_SLL:  alu_out = src1 << shamt;
            ALU_SLT:  alu_out = {{(`EXEC_XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLTU: alu_out = {{(`EXEC_XLEN-1){1'b0}}, src1 < src2};
            ALU_XOR:  alu_out = src1 ^ src2;
            ALU_SRL:  alu_out = src1 >> shamt;
            ALU_SRA:  alu_out = $signed(src1) >>> shamt;
            ALU_OR:   alu_out = src1 | src2;
            ALU_AND:  alu_out = src1 & src2;
            default:  alu_out = '0;
        endcase
    end

    always_comb begin
        result_next.value      = alu_out ^ {{(`EXEC_XLEN-1){1'b0}}, uop.invert};
        result_next.store_data = uop.rs2_value;
        result_next.pc         = uop.pc;
        result_next.rd         = uop.rd;
        result_next.reg_write  = uop.reg_write;
        result_next.mem_read   = uop.mem_read;
        result_next.mem_write  = uop.mem_write;
    end

    // the dispatcher never loads a busy lane, so load and pop never meet here.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (load) begin
            busy <= 1'b1;
        end else if (pop) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            result <= result_next; // held until popped.
        end
    end

endmodule

// ==== hw/issue_dispatch.sv ====
`timescale 1ns/1ps
`include "exec_cluster_config.svh"

module issue_dispatch (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`EXEC_LANES-1:0] lane_busy,
    output logic [`EXEC_LANES-1:0] lane_load
);

    localparam int PTR_W = (`EXEC_LANES > 1) ? $clog2(`EXEC_LANES) : 1;

    logic [PTR_W-1:0] issue_ptr;
    logic             in_fire;

    // registered busy only, no pop bypass.
    assign in_ready = ~lane_busy[issue_ptr];
    assign in_fire  = in_valid && in_ready;

    always_comb begin
        for (int i = 0; i < `EXEC_LANES; i++) begin
            lane_load[i] = in_fire && (issue_ptr == PTR_W'(i));
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            issue_ptr <= '0;
        end else if (in_fire) begin
            if (issue_ptr == PTR_W'(`EXEC_LANES - 1)) begin
                issue_ptr <= '0;
            end else begin
                issue_ptr <= issue_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hw/result_retire.sv ====
`timescale 1ns/1ps
`include "exec_cluster_config.svh"

module result_retire (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic [`EXEC_LANES-1:0]                  lane_busy,
    input  exec_pkg::result_t [`EXEC_LANES-1:0]     lane_result,
    output logic [`EXEC_LANES-1:0]                  lane_pop,
    output logic                                    out_valid,
    output exec_pkg::result_t                       out_result,
    input  logic                                    out_ready
);

    localparam int PTR_W = (`EXEC_LANES > 1) ? $clog2(`EXEC_LANES) : 1;

    logic [PTR_W-1:0] retire_ptr;
    logic             out_fire;

    // same rotation as the dispatcher keeps program order.
    assign out_valid  = lane_busy[retire_ptr];
    assign out_result = lane_result[retire_ptr];
    assign out_fire   = out_valid && out_ready;

    always_comb begin
        for (int i = 0; i < `EXEC_LANES; i++) begin
            lane_pop[i] = out_fire && (retire_ptr == PTR_W'(i));
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            retire_ptr <= '0;
        end else if (out_fire) begin
            if (retire_ptr == PTR_W'(`EXEC_LANES - 1)) begin
                retire_ptr <= '0;
            end else begin
                retire_ptr <= retire_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hw/exec_cluster.sv ====
`timescale 1ns/1ps
`include "exec_cluster_config.svh"

module exec_cluster (
    input  logic              clock,
    input  logic              reset,
    input  logic              in_valid,
    input  exec_pkg::uop_t    in_uop,
    output logic              in_ready,
    output logic              out_valid,
    output exec_pkg::result_t out_result,
    input  logic              out_ready
);
    import exec_pkg::*;

    logic [`EXEC_LANES-1:0]    lane_load;
    logic [`EXEC_LANES-1:0]    lane_busy;
    logic [`EXEC_LANES-1:0]    lane_pop;
    result_t [`EXEC_LANES-1:0] lane_result;

    issue_dispatch u_dispatch (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .lane_busy (lane_busy),
        .lane_load (lane_load)
    );

    // every lane sees the micro-op, only the loaded one takes it.
    for (genvar g = 0; g < `EXEC_LANES; g++) begin : g_lane
        exu_lane u_lane (
            .clock  (clock),
            .reset  (reset),
            .load   (lane_load[g]),
            .uop    (in_uop),
            .pop    (lane_pop[g]),
            .busy   (lane_busy[g]),
            .result (lane_result[g])
        );
    end

    result_retire u_retire (
        .clock       (clock),
        .reset       (reset),
        .lane_busy   (lane_busy),
        .lane_result (lane_result),
        .lane_pop    (lane_pop),
        .out_valid   (out_valid),
        .out_result  (out_result),
        .out_ready   (out_ready)
    );

endmodule

// ==== verif/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock; // 100 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// ==== verif/exec_cluster_asserts.sv ====
`timescale 1ns/1ps
`include "exec_cluster_config.svh"

module exec_cluster_asserts (
    input logic                   clock,
    input logic                   reset,
    input logic                   out_valid,
    input logic                   out_ready,
    input exec_pkg::result_t      out_result,
    input logic [`EXEC_LANES-1:0] lane_load,
    input logic [`EXEC_LANES-1:0] lane_busy
);
    import exec_pkg::*;

    load_onehot: assert property (@(posedge clock) disable iff (reset) $onehot0(lane_load))
        else $error("lane_load has more than one bit set");

    // a busy lane still holds an unretired result.
    load_free_lane: assert property (@(posedge clock) disable iff (reset)
        (lane_load & lane_busy) == '0)
        else $error("a busy lane was loaded");

    out_hold: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else $error("output changed while stalled");

    out_quiet_after_reset: assert property (@(posedge clock) $past(reset) |-> !out_valid)
        else $error("out_valid high right after reset");

endmodule

bind exec_cluster exec_cluster_asserts u_asserts (.*);

// ==== verif/exec_cluster_tb.sv ====
`timescale 1ns/1ps
`include "exec_cluster_config.svh"

module exec_cluster_tb;
    import exec_pkg::*;

    localparam int NUM_VEC     = 30;
    localparam int WORDS       = 15;
    localparam int DIRECT_VEC  = 6;  // sent back to back with the latency checked.
    localparam int CYCLE_LIMIT = NUM_VEC * 16 + 100;
    localparam logic [31:0] SEED = 32'hca0d_dbdd;

    logic        clock;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    logic        out_valid;
    logic        out_ready = 1'b1;
    logic [1:0]  ready_mode = 2'd1; // 0 low, 1 high, 2 random.
    uop_t        in_uop;
    result_t     out_result;
    logic [31:0] golden_mem [NUM_VEC*WORDS];
    uop_t        uops [NUM_VEC];
    result_t     exp_queue [$];
    int          accept_cycle [$];
    int          cycle_count;
    int          seen_count;
    int          accept_count;
    logic [31:0] bubble_state;
    logic [31:0] ready_state;

    clock_gen u_clock (.clock(clock), .reset(reset));

    exec_cluster u_dut (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_result (out_result),
        .out_ready  (out_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_result(input result_t got, input result_t exp);
        logic bad;
        bad = 1'b0;
        if (got.value !== exp.value) begin
            $display("[FAIL] out_result.value got %h expected %h", got.value, exp.value);
            bad = 1'b1;
        end
        if (got.store_data !== exp.store_data) begin
            $display("[FAIL] out_result.store_data got %h expected %h",
                     got.store_data, exp.store_data);
            bad = 1'b1;
        end
        if (got.pc !== exp.pc) begin
            $display("[FAIL] out_result.pc got %h expected %h", got.pc, exp.pc);
            bad = 1'b1;
        end
        if ({got.rd, got.reg_write, got.mem_read, got.mem_write} !==
            {exp.rd, exp.reg_write, exp.mem_read, exp.mem_write}) begin
            $display("[FAIL] out_result.rd/reg_write/mem_read/mem_write got %h expected %h",
                     {got.rd, got.reg_write, got.mem_read, got.mem_write},
                     {exp.rd, exp.reg_write, exp.mem_read, exp.mem_write});
            bad = 1'b1;
        end
        if (bad) begin
            stop_on_error();
        end
    endtask

    // one line per vector with the expected value as its last word.
    task automatic load_vectors();
        int      base;
        uop_t    u;
        result_t r;
        $readmemh("verif/exec_cluster_golden.txt", golden_mem);
        for (int i = 0; i < NUM_VEC; i++) begin
            base        = i * WORDS;
            u.pc        = golden_mem[base];
            u.rs1_value = golden_mem[base+1];
            u.rs2_value = golden_mem[base+2];
            u.csr_value = golden_mem[base+3];
            u.imm       = golden_mem[base+4];
            u.imm_kind  = imm_kind_e'(golden_mem[base+5][1:0]);
            u.alu_op    = alu_op_e'(golden_mem[base+6][3:0]);
            u.src1_sel  = src1_sel_e'(golden_mem[base+7][1:0]);
            u.src2_sel  = src2_sel_e'(golden_mem[base+8][1:0]);
            u.invert    = golden_mem[base+9][0];
            u.rd        = golden_mem[base+10][4:0];
            u.reg_write = golden_mem[base+11][0];
            u.mem_read  = golden_mem[base+12][0];
            u.mem_write = golden_mem[base+13][0];
            r.value      = golden_mem[base+14];
            r.store_data = u.rs2_value;
            r.pc         = u.pc;
            r.rd         = u.rd;
            r.reg_write  = u.reg_write;
            r.mem_read   = u.mem_read;
            r.mem_write  = u.mem_write;
            uops[i] = u;
            exp_queue.push_back(r);
        end
    endtask

    // holds the vector on the bus until the edge where it is taken.
    task automatic send_vector(input int idx);
        in_valid <= 1'b1;
        in_uop   <= uops[idx];
        do begin
            @(posedge clock);
        end while (!in_ready);
    endtask

    always @(posedge clock) begin
        if (ready_mode == 2'd2) begin
            ready_state <= lcg_next(ready_state);
            out_ready   <= (ready_state[23:16] % 3) != 0;
        end else begin
            out_ready <= ready_mode[0];
        end
    end

    always @(posedge clock) begin : monitor
        int in_cycle;
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout, results still missing after %0d cycles", CYCLE_LIMIT);
            stop_on_error();
        end else if (!reset) begin
            if (in_valid && in_ready) begin
                accept_cycle.push_back(cycle_count);
                accept_count++;
            end
            if (out_valid && out_ready) begin
                if (exp_queue.size() == 0 || accept_cycle.size() == 0) begin
                    $display("an output transfer came with no result outstanding");
                    stop_on_error();
                end else begin
                    in_cycle = accept_cycle.pop_front();
                    check_result(out_result, exp_queue.pop_front());
                    seen_count++;
                    if (seen_count <= DIRECT_VEC && cycle_count != in_cycle + 1) begin
                        $display("result %0d came %0d cycles after its input, not one",
                                 seen_count - 1, cycle_count - in_cycle);
                        stop_on_error();
                    end
                end
            end
        end
    end

    initial begin
        in_valid     = 1'b0;
        in_uop       = '0;
        cycle_count  = 0;
        seen_count   = 0;
        accept_count = 0;
        bubble_state = SEED;
        ready_state  = lcg_next(SEED);
        load_vectors();

        @(negedge reset);
        @(posedge clock);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);

        for (int i = 0; i < DIRECT_VEC; i++) begin
            send_vector(i);
        end
        in_valid <= 1'b0;
        repeat (2) @(posedge clock);

        // with the output blocked the lanes fill and in_ready drops.
        ready_mode <= 2'd0;
        for (int i = DIRECT_VEC; i < DIRECT_VEC + `EXEC_LANES; i++) begin
            send_vector(i);
        end
        in_valid <= 1'b1;
        in_uop   <= uops[DIRECT_VEC + `EXEC_LANES];
        repeat (4) begin
            @(posedge clock);
            check_flag("in_ready", in_ready, 1'b0);
        end

        ready_mode <= 2'd2;
        for (int i = DIRECT_VEC + `EXEC_LANES; i < NUM_VEC; i++) begin
            bubble_state = lcg_next(bubble_state);
            if (i > DIRECT_VEC + `EXEC_LANES && bubble_state[31:30] == 2'd0) begin
                in_valid <= 1'b0;
                @(posedge clock);
            end
            send_vector(i);
        end
        in_valid <= 1'b0;

        wait (seen_count == NUM_VEC);
        @(posedge clock);
        if (exp_queue.size() == 0 && accept_count == NUM_VEC && !out_valid) begin
            $display("test passed");
            $finish;
        end else begin
            $display("test failed");
            $fatal(1, "a result is still pending after the last expected one");
        end
    end

endmodule

// ==== exec_cluster.f ====
+incdir+common
common/exec_pkg.sv
exu/exu_lane.sv
hw/issue_dispatch.sv
hw/result_retire.sv
hw/exec_cluster.sv
verif/clock_gen.sv
verif/exec_cluster_asserts.sv
verif/exec_cluster_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= exec_cluster_tb
FILELIST   ?= exec_cluster.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
PASS_TEXT  ?= test passed

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/exec_cluster_config.svh
GOLDEN  := verif/exec_cluster_golden.txt
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

$(LOG): $(SIM_BIN) $(GOLDEN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)

run: $(LOG)

check: $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/exec_cluster_golden.txt ====
// pc rs1 rs2 csr imm imm_kind alu_op src1_sel src2_sel invert rd reg_write mem_read mem_write
// then the expected result value, all in hex
00000100 00000005 00000003 00000000 00000000 0 0 0 1 0 01 1 0 0 00000008
00000104 fffffff0 00000020 00000000 00000000 0 0 0 1 0 02 1 0 0 00000010
00000108 00000003 00000005 00000000 00000000 0 1 0 1 0 03 1 0 0 fffffffe
0000010c 80000000 00000001 00000000 00000000 0 1 0 1 0 04 1 0 0 7fffffff
00000110 00000001 0000001f 00000000 00000000 0 2 0 1 0 05 1 0 0 80000000
00000114 12345678 00000024 00000000 00000000 0 2 0 1 0 06 1 0 0 23456780
00000118 ffffffff 00000001 00000000 00000000 0 3 0 1 0 07 1 0 0 00000001
0000011c ffffffff 00000001 00000000 00000000 0 4 0 1 0 08 1 0 0 00000000
00000120 00000005 fffffffb 00000000 00000000 0 3 0 1 0 09 1 0 0 00000000
00000124 00000005 fffffffb 00000000 00000000 0 4 0 1 0 0a 1 0 0 00000001
00000128 f0f0f0f0 0ff00ff0 00000000 00000000 0 5 0 1 0 0b 1 0 0 ff00ff00
0000012c 80000000 0000001f 00000000 00000000 0 6 0 1 0 0c 1 0 0 00000001
00000130 f0000000 00000004 00000000 00000000 0 6 0 1 0 0d 1 0 0 0f000000
00000134 80000000 0000001f 00000000 00000000 0 7 0 1 0 0e 1 0 0 ffffffff
00000138 f0000000 00000004 00000000 00000000 0 7 0 1 0 0f 1 0 0 ff000000
0000013c 00ff0000 000000ff 00000000 00000000 0 8 0 1 0 10 1 0 0 00ff00ff
00000140 ff00ff00 0ff00ff0 00000000 00000000 0 9 0 1 0 11 1 0 0 0f000f00
00000144 7ffffff0 00000004 00000000 00000000 0 7 0 1 0 12 1 0 0 07ffffff
00000148 00000100 00000055 00000000 00000800 0 0 0 0 0 13 1 1 0 fffff900
0000014c 11111111 00000000 00000000 000007ff 0 0 2 0 0 14 1 0 0 000007ff
00001000 00000000 00000000 00000000 00012345 1 0 1 0 0 15 1 0 0 12346000
00000150 00000000 00000000 00000000 000fffff 1 0 2 0 0 16 1 0 0 fffff000
00002000 00000000 00000000 00000000 000ffffe 2 0 1 0 0 17 1 0 0 00001ffc
00000154 00000000 00000000 00000000 00000400 2 0 2 0 0 18 1 0 0 00000800
00000158 00000010 a5a5a5a5 00000000 0000003f 3 0 0 0 0 19 0 0 1 0000002f
0000015c 00000000 00000000 deadbeef 00000000 0 8 2 2 0 1a 1 0 0 deadbeef
00000160 0000ffff 00000000 12345678 00000000 0 9 0 2 0 1b 1 0 0 00005678
00000164 ffffffff 00000001 00000000 00000000 0 3 0 1 1 1c 1 0 0 00000000
00000168 00000005 fffffffb 00000000 00000000 0 3 0 1 1 1d 0 1 0 00000001
0000016c cafef00d 00000077 00000000 00000000 0 0 0 3 0 1e 1 0 1 cafef00d
